// ==== project.f ====
src/sysctl_pkg.sv
src/pad_pkg.sv
src/bus_decode.sv
src/sysctl_regs.sv
src/pin_router.sv
src/gpio_sysctl.sv
test/tb_gpio_sysctl.sv

// ==== Makefile ====
# Verilator build for the gpio system control peripheral

TOOL     := verilator
TOP      := tb_gpio_sysctl
RTL_TOP  := gpio_sysctl
FLIST    := project.f
FLAGS    := --timing --assert
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)

sim: $(OBJ_DIR)/$(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_gpio_sysctl.sv ====
// testbench for the gpio system control peripheral
// directed tests of reset, byte lanes, pin routing, irq selection,
// decoding and pipelined access against a register model

`timescale 1ns/100ps
`default_nettype none

module tb_gpio_sysctl
  import sysctl_pkg::*;
  import pad_pkg::*;
();

  localparam int    CLK_PERIOD = 10;
  localparam int    NUM_TESTS  = 6;
  localparam addr_t BASE_ADDR  = 32'h0300_0000;

  logic       clk_i;
  logic       rst_n_i;
  logic       req_valid_i;
  bus_req_t   req_i;
  gpio_t      gpio_in_i;
  logic       xtal_i;
  logic       clk_pll_i;
  logic       trap_i;
  logic       rsp_valid_o;
  data_t      rsp_rdata_o;
  gpio_t      gpio_out_o;
  gpio_t      gpio_outenb_o;
  gpio_t      gpio_pullupb_o;
  gpio_t      gpio_pulldownb_o;
  logic [1:0] irq_o;

  int     errors = 0;
  integer seed   = 32'h3ad9_32f2;

  // register model
  gpio_t      exp_gpio;
  gpio_t      exp_oeb;
  gpio_t      exp_pu;
  gpio_t      exp_pd;
  route_sel_t exp_xtal;
  route_sel_t exp_pll;
  route_sel_t exp_trap;
  route_sel_t exp_irq7;
  route_sel_t exp_irq8;

  gpio_sysctl #(
    .BASE_ADDR(BASE_ADDR)
  ) gpio_sysctl_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .gpio_in_i       (gpio_in_i),
    .xtal_i          (xtal_i),
    .clk_pll_i       (clk_pll_i),
    .trap_i          (trap_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_rdata_o     (rsp_rdata_o),
    .gpio_out_o      (gpio_out_o),
    .gpio_outenb_o   (gpio_outenb_o),
    .gpio_pullupb_o  (gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o),
    .irq_o           (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic compare(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic gpio_t merge_lanes(gpio_t cur, data_t wdata, strb_t wstrb);
    gpio_t res;
    res = cur;
    if (wstrb[0])
      res[7:0] = wdata[7:0];
    if (wstrb[1])
      res[15:8] = wdata[15:8];
    return res;
  endfunction

  function automatic data_t model_read(logic [PAGE_BITS-1:0] ofs);
    case (ofs)
      OFS_GPIO: return {exp_gpio, gpio_in_i};
      OFS_OEB:  return data_t'(exp_oeb);
      OFS_PU:   return data_t'(exp_pu);
      OFS_PD:   return data_t'(exp_pd);
      OFS_XTAL: return data_t'(exp_xtal);
      OFS_PLL:  return data_t'(exp_pll);
      OFS_TRAP: return data_t'(exp_trap);
      OFS_IRQ7: return data_t'(exp_irq7);
      OFS_IRQ8: return data_t'(exp_irq8);
      default:  return '0;
    endcase
  endfunction

  task automatic model_write(input logic [PAGE_BITS-1:0] ofs, input data_t wdata,
                             input strb_t wstrb);
    case (ofs)
      OFS_GPIO: exp_gpio = merge_lanes(exp_gpio, wdata, wstrb);
      OFS_OEB:  exp_oeb = merge_lanes(exp_oeb, wdata, wstrb);
      OFS_PU:   exp_pu = merge_lanes(exp_pu, wdata, wstrb);
      OFS_PD:   exp_pd = merge_lanes(exp_pd, wdata, wstrb);
      OFS_XTAL: exp_xtal = wstrb[0] ? wdata[1:0] : exp_xtal;
      OFS_PLL:  exp_pll = wstrb[0] ? wdata[1:0] : exp_pll;
      OFS_TRAP: exp_trap = wstrb[0] ? wdata[1:0] : exp_trap;
      OFS_IRQ7: exp_irq7 = wstrb[0] ? wdata[1:0] : exp_irq7;
      OFS_IRQ8: exp_irq8 = wstrb[0] ? wdata[1:0] : exp_irq8;
      default: ;
    endcase
  endtask

  // one strobe, then wait for the response
  task automatic access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                        output data_t rdata);
    int waited;
    next_cycle();
    req_valid_i = 1'b1;
    req_i = '{addr: addr, wdata: wdata, wstrb: wstrb};
    next_cycle();
    req_valid_i = 1'b0;
    waited = 1;
    while (!rsp_valid_o && waited < 4) begin
      next_cycle();
      waited++;
    end
    assert (rsp_valid_o && waited == 2) else begin
      errors++;
      $display("response to %h not seen two cycles after its request", addr);
    end
    rdata = rsp_rdata_o;
  endtask

  task automatic write_reg(input logic [PAGE_BITS-1:0] ofs, input data_t wdata,
                           input strb_t wstrb);
    data_t exp;
    data_t got;
    exp = model_read(ofs);
    access(BASE_ADDR | addr_t'(ofs), wdata, wstrb, got);
    compare("rsp_rdata_o", got, exp);
    model_write(ofs, wdata, wstrb);
  endtask

  task automatic read_reg(input logic [PAGE_BITS-1:0] ofs);
    data_t exp;
    data_t got;
    exp = model_read(ofs);
    access(BASE_ADDR | addr_t'(ofs), '0, '0, got);
    compare("rsp_rdata_o", got, exp);
  endtask

  task automatic read_all();
    logic [PAGE_BITS-1:0] all_ofs [9];
    all_ofs = '{OFS_GPIO, OFS_OEB, OFS_PU, OFS_PD, OFS_XTAL, OFS_PLL, OFS_TRAP,
                OFS_IRQ7, OFS_IRQ8};
    for (int i = 0; i < 9; i++)
      read_reg(all_ofs[i]);
  endtask

  // mask marks a routed group
  task automatic compare_pads(input gpio_t exp_out, input gpio_t mask);
    compare("gpio_out_o", data_t'(gpio_out_o), data_t'(exp_out));
    compare("gpio_outenb_o", data_t'(gpio_outenb_o), data_t'(exp_oeb & ~mask));
    compare("gpio_pullupb_o", data_t'(gpio_pullupb_o), data_t'(exp_pu | mask));
    compare("gpio_pulldownb_o", data_t'(gpio_pulldownb_o), data_t'(exp_pd | mask));
  endtask

  function automatic gpio_t route_pin(gpio_t pin, logic val);
    return (exp_gpio & ~pin) | (val ? pin : '0);
  endfunction

  function automatic logic expected_irq_bit(gpio_t in, int sel, int first);
    gpio_t shifted;
    shifted = in >> (first + sel - 1);
    return (sel == 0) ? 1'b0 : shifted[0];
  endfunction

  task automatic check_reset();
    rst_n_i = 1'b0;
    repeat (5) begin
      next_cycle();
      compare("gpio_outenb_o", data_t'(gpio_outenb_o), data_t'(16'hffff));
    end
    rst_n_i = 1'b1;
    read_all();
    compare_pads(exp_gpio, '0);
  endtask

  task automatic check_byte_lanes();
    logic [PAGE_BITS-1:0] ofs_list [4];
    ofs_list = '{OFS_GPIO, OFS_OEB, OFS_PU, OFS_PD};
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < 4; k++) begin
        gpio_in_i = gpio_t'($random(seed));
        write_reg(ofs_list[r], data_t'($random(seed)), strb_t'($random(seed)));
        read_reg(ofs_list[r]);
        read_reg(OFS_GPIO);
        compare_pads(exp_gpio, '0);
      end
    end
  endtask

  task automatic check_routing();
    logic [PAGE_BITS-1:0] ofs;
    int    base;
    int    last;
    gpio_t mask;
    gpio_t pin;
    logic  pll_clk;
    for (int g = 0; g < 3; g++) begin
      base = 5 + 3 * g;
      ofs = (g == 0) ? OFS_XTAL : (g == 1) ? OFS_PLL : OFS_TRAP;
      last = (g == 1) ? 2 : 3;
      mask = gpio_t'(3'b111) << base;
      for (int v = 1; v <= last; v++) begin
        pin = gpio_t'(1) << (base + v - 1);
        pll_clk = (g == 1 && v == 2);
        write_reg(ofs, data_t'(v), 4'h1);
        for (int lvl = 0; lvl < 2; lvl++) begin
          next_cycle();
          xtal_i = lvl[0];
          clk_pll_i = lvl[0];
          trap_i = lvl[0];
          // clk_i high here, low five ns later
          #1;
          compare_pads(route_pin(pin, pll_clk ? 1'b1 : lvl[0]), mask);
          #5;
          compare_pads(route_pin(pin, pll_clk ? 1'b0 : lvl[0]), mask);
        end
      end
      write_reg(ofs, '0, 4'h1);
    end
    xtal_i = 1'b0;
    clk_pll_i = 1'b0;
    trap_i = 1'b0;
  endtask

  task automatic check_irq();
    logic [1:0] exp_irq;
    for (int v = 0; v < 4; v++) begin
      write_reg(OFS_IRQ7, data_t'(v), 4'h1);
      write_reg(OFS_IRQ8, data_t'(3 - v), 4'h1);
      repeat (4) begin
        next_cycle();
        gpio_in_i = gpio_t'($random(seed));
        #1;
        exp_irq = {expected_irq_bit(gpio_in_i, 3 - v, 3), expected_irq_bit(gpio_in_i, v, 0)};
        compare("irq_o", data_t'(irq_o), data_t'(exp_irq));
      end
    end
  endtask

  task automatic check_decode();
    next_cycle();
    req_valid_i = 1'b1;
    req_i = '{addr: BASE_ADDR ^ 32'h0001_0000, wdata: 32'hffff_ffff, wstrb: 4'hf};
    next_cycle();
    req_valid_i = 1'b0;
    repeat (4) begin
      assert (!rsp_valid_o) else begin
        errors++;
        $display("response at %0t to a request outside the page", $time);
      end
      next_cycle();
    end
    write_reg(8'h10, data_t'($random(seed)), 4'hf);
    write_reg(8'h48, data_t'($random(seed)), 4'hf);
    read_reg(8'h10);
    read_all();
  endtask

  task automatic check_pipeline();
    logic [PAGE_BITS-1:0] ofs_seq [6];
    strb_t                strb_seq [6];
    data_t                wdata_seq [6];
    data_t                exp_q [$];
    ofs_seq = '{OFS_GPIO, OFS_GPIO, OFS_PU, OFS_PU, OFS_IRQ7, OFS_IRQ7};
    strb_seq = '{4'h3, 4'h0, 4'h1, 4'h0, 4'h1, 4'h0};
    for (int i = 0; i < 6; i++)
      wdata_seq[i] = data_t'($random(seed));
    for (int t = 0; t < 8; t++) begin
      next_cycle();
      // response of the request issued two cycles ago
      if (t >= 2) begin
        assert (rsp_valid_o) else begin
          errors++;
          $display("pipelined response %0d missing at %0t", t - 2, $time);
        end
        compare("rsp_rdata_o", rsp_rdata_o, exp_q.pop_front());
      end else begin
        assert (!rsp_valid_o) else begin
          errors++;
          $display("unexpected response at %0t", $time);
        end
      end
      if (t < 6) begin
        exp_q.push_back(model_read(ofs_seq[t]));
        model_write(ofs_seq[t], wdata_seq[t], strb_seq[t]);
        req_valid_i = 1'b1;
        req_i = '{addr: BASE_ADDR | addr_t'(ofs_seq[t]), wdata: wdata_seq[t],
                  wstrb: strb_seq[t]};
      end else begin
        req_valid_i = 1'b0;
      end
    end
    compare_pads(exp_gpio, '0);
  endtask

  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    gpio_in_i = 16'h5a3c;
    xtal_i = 1'b0;
    clk_pll_i = 1'b0;
    trap_i = 1'b0;
    exp_gpio = '0;
    exp_oeb = '1;
    exp_pu = '0;
    exp_pd = '0;
    exp_xtal = '0;
    exp_pll = '0;
    exp_trap = '0;
    exp_irq7 = '0;
    exp_irq8 = '0;
    check_reset();
    check_byte_lanes();
    check_routing();
    check_irq();
    check_decode();
    check_pipeline();
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/gpio_sysctl.sv ====
// gpio system control peripheral
// decode, register and pad routing stages behind a strobe bus,
// two cycles from request to response

`timescale 1ns/100ps
`default_nettype none

module gpio_sysctl
  import sysctl_pkg::*;
  import pad_pkg::*;
#(
  parameter addr_t BASE_ADDR = 32'h0300_0000
) (
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire logic     req_valid_i,
  input  wire bus_req_t req_i,
  input  wire gpio_t    gpio_in_i,
  input  wire logic     xtal_i,
  input  wire logic     clk_pll_i,
  input  wire logic     trap_i,
  output logic          rsp_valid_o,
  output data_t         rsp_rdata_o,
  output gpio_t         gpio_out_o,
  output gpio_t         gpio_outenb_o,
  output gpio_t         gpio_pullupb_o,
  output gpio_t         gpio_pulldownb_o,
  output logic [1:0]    irq_o
);

  logic     dec_valid;
  dec_req_t dec;
  pad_cfg_t cfg;
  pad_out_t pads;

  bus_decode #(
    .BASE_ADDR(BASE_ADDR)
  ) bus_decode_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(req_valid_i),
    .req_i      (req_i),
    .dec_valid_o(dec_valid),
    .dec_o      (dec)
  );

  // pad outputs loop back for the gpio data readback
  sysctl_regs sysctl_regs_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .dec_valid_i(dec_valid),
    .dec_i      (dec),
    .gpio_in_i  (gpio_in_i),
    .pad_out_i  (pads.out),
    .cfg_o      (cfg),
    .rsp_valid_o(rsp_valid_o),
    .rsp_rdata_o(rsp_rdata_o)
  );

  pin_router pin_router_i (
    .rst_n_i  (rst_n_i),
    .clk_i    (clk_i),
    .xtal_i   (xtal_i),
    .clk_pll_i(clk_pll_i),
    .trap_i   (trap_i),
    .cfg_i    (cfg),
    .gpio_in_i(gpio_in_i),
    .pads_o   (pads),
    .irq_o    (irq_o)
  );

  assign gpio_out_o       = pads.out;
  assign gpio_outenb_o    = pads.outenb;
  assign gpio_pullupb_o   = pads.pullupb;
  assign gpio_pulldownb_o = pads.pulldownb;

endmodule

`default_nettype wire

// ==== src/pin_router.sv ====
// pad routing stage
// puts the crystal, pll clock and trap onto their gpio pins,
// overrides the pad controls of routed groups and picks the irq sources

`timescale 1ns/100ps
`default_nettype none

module pin_router
  import pad_pkg::*;
(
  input  wire logic     rst_n_i,
  input  wire logic     clk_i,
  input  wire logic     xtal_i,
  input  wire logic     clk_pll_i,
  input  wire logic     trap_i,
  input  wire pad_cfg_t cfg_i,
  input  wire gpio_t    gpio_in_i,
  output pad_out_t      pads_o,
  output logic [1:0]    irq_o
);

  localparam gpio_t XTAL_PINS = 16'h00e0;
  localparam gpio_t PLL_PINS  = 16'h0700;
  localparam gpio_t TRAP_PINS = 16'h3800;

  gpio_t ovr;
  gpio_t out;

  function automatic logic pick_irq(route_sel_t src, logic [2:0] bits);
    logic res;
    case (src)
      2'd1:    res = bits[0];
      2'd2:    res = bits[1];
      2'd3:    res = bits[2];
      default: res = 1'b0;
    endcase
    return res;
  endfunction

  // whole group is driven once its selector is set
  assign ovr = (cfg_i.xtal_dest != '0 ? XTAL_PINS : '0) |
               (cfg_i.pll_dest != '0 ? PLL_PINS : '0) |
               (cfg_i.trap_dest != '0 ? TRAP_PINS : '0);

  always_comb begin
    out = cfg_i.gpio;
    case (cfg_i.xtal_dest)
      2'd1:    out[5] = xtal_i;
      2'd2:    out[6] = xtal_i;
      2'd3:    out[7] = xtal_i;
      default: ;
    endcase
    // pin 10 stays plain gpio even when pll group is taken
    case (cfg_i.pll_dest)
      2'd1:    out[8] = clk_pll_i;
      2'd2:    out[9] = clk_i;
      default: ;
    endcase
    case (cfg_i.trap_dest)
      2'd1:    out[11] = trap_i;
      2'd2:    out[12] = trap_i;
      2'd3:    out[13] = trap_i;
      default: ;
    endcase
  end

  assign pads_o.out       = out;
  assign pads_o.outenb    = (cfg_i.oeb & ~ovr) | {GPIO_W{~rst_n_i}};
  assign pads_o.pullupb   = cfg_i.pu | ovr;
  assign pads_o.pulldownb = cfg_i.pd | ovr;

  assign irq_o = {pick_irq(cfg_i.irq8_src, gpio_in_i[5:3]),
                  pick_irq(cfg_i.irq7_src, gpio_in_i[2:0])};

  // routed sources stay inside their own group
  a_route_in_group: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ((pads_o.out ^ cfg_i.gpio) & ~ovr) == '0
  );

endmodule

`default_nettype wire

// ==== src/sysctl_regs.sv ====
// system control register stage
// holds the gpio and routing registers, applies byte lane writes
// and returns the pre-write value as a registered response

`timescale 1ns/100ps
`default_nettype none

module sysctl_regs
  import sysctl_pkg::*;
  import pad_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire logic     dec_valid_i,
  input  wire dec_req_t dec_i,
  input  wire gpio_t    gpio_in_i,
  input  wire gpio_t    pad_out_i,
  output pad_cfg_t      cfg_o,
  output logic          rsp_valid_o,
  output data_t         rsp_rdata_o
);

  pad_cfg_t cfg_q;
  data_t    rdata;

  // lane 0 feeds bits 7:0, lane 1 bits 15:8
  function automatic gpio_t lane_wr(gpio_t old, data_t wdata, strb_t wstrb);
    gpio_t res;
    res = old;
    if (wstrb[0]) begin
      res[7:0] = wdata[7:0];
    end
    if (wstrb[1]) begin
      res[15:8] = wdata[15:8];
    end
    return res;
  endfunction

  function automatic route_sel_t sel_wr(route_sel_t old, data_t wdata, strb_t wstrb);
    route_sel_t res;
    res = wstrb[0] ? wdata[1:0] : old;
    return res;
  endfunction

  // a zero strobe leaves every register untouched
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '{oeb: '1, default: '0};
    end else if (dec_valid_i) begin
      case (dec_i.sel)
        SEL_GPIO: cfg_q.gpio      <= lane_wr(cfg_q.gpio, dec_i.wdata, dec_i.wstrb);
        SEL_OEB:  cfg_q.oeb       <= lane_wr(cfg_q.oeb, dec_i.wdata, dec_i.wstrb);
        SEL_PU:   cfg_q.pu        <= lane_wr(cfg_q.pu, dec_i.wdata, dec_i.wstrb);
        SEL_PD:   cfg_q.pd        <= lane_wr(cfg_q.pd, dec_i.wdata, dec_i.wstrb);
        SEL_XTAL: cfg_q.xtal_dest <= sel_wr(cfg_q.xtal_dest, dec_i.wdata, dec_i.wstrb);
        SEL_PLL:  cfg_q.pll_dest  <= sel_wr(cfg_q.pll_dest, dec_i.wdata, dec_i.wstrb);
        SEL_TRAP: cfg_q.trap_dest <= sel_wr(cfg_q.trap_dest, dec_i.wdata, dec_i.wstrb);
        SEL_IRQ7: cfg_q.irq7_src  <= sel_wr(cfg_q.irq7_src, dec_i.wdata, dec_i.wstrb);
        SEL_IRQ8: cfg_q.irq8_src  <= sel_wr(cfg_q.irq8_src, dec_i.wdata, dec_i.wstrb);
        default: ;
      endcase
    end
  end

  // read word from the value before this write
  always_comb begin
    case (dec_i.sel)
      SEL_GPIO: rdata = {pad_out_i, gpio_in_i};
      SEL_OEB:  rdata = data_t'(cfg_q.oeb);
      SEL_PU:   rdata = data_t'(cfg_q.pu);
      SEL_PD:   rdata = data_t'(cfg_q.pd);
      SEL_XTAL: rdata = data_t'(cfg_q.xtal_dest);
      SEL_PLL:  rdata = data_t'(cfg_q.pll_dest);
      SEL_TRAP: rdata = data_t'(cfg_q.trap_dest);
      SEL_IRQ7: rdata = data_t'(cfg_q.irq7_src);
      SEL_IRQ8: rdata = data_t'(cfg_q.irq8_src);
      default:  rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      rsp_rdata_o <= rdata;
    end
  end

  assign cfg_o = cfg_q;

  // a read request never disturbs the registers
  a_read_keeps_regs: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_i && dec_i.wstrb == '0 |=> $stable(cfg_q)
  );

endmodule

`default_nettype wire

// ==== src/bus_decode.sv ====
// bus decode stage
// checks a request against the register page and maps its
// offset to a register select, registered for the next stage

`timescale 1ns/100ps
`default_nettype none

module bus_decode
  import sysctl_pkg::*;
#(
  parameter addr_t BASE_ADDR = 32'h0300_0000
) (
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire logic     req_valid_i,
  input  wire bus_req_t req_i,
  output logic          dec_valid_o,
  output dec_req_t      dec_o
);

  logic     page_hit;
  reg_sel_e sel;

  // low page bits of the base are ignored
  assign page_hit = req_i.addr[ADDR_W-1:PAGE_BITS] == BASE_ADDR[ADDR_W-1:PAGE_BITS];

  always_comb begin
    case (req_i.addr[PAGE_BITS-1:0])
      OFS_GPIO: sel = SEL_GPIO;
      OFS_OEB:  sel = SEL_OEB;
      OFS_PU:   sel = SEL_PU;
      OFS_PD:   sel = SEL_PD;
      OFS_XTAL: sel = SEL_XTAL;
      OFS_PLL:  sel = SEL_PLL;
      OFS_TRAP: sel = SEL_TRAP;
      OFS_IRQ7: sel = SEL_IRQ7;
      OFS_IRQ8: sel = SEL_IRQ8;
      default:  sel = SEL_NONE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= req_valid_i && page_hit;
    end
  end

  // payload only moves on a page hit
  always_ff @(posedge clk_i) begin
    if (req_valid_i && page_hit) begin
      dec_o <= '{sel: sel, wdata: req_i.wdata, wstrb: req_i.wstrb};
    end
  end

  a_req_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> !$isunknown(req_i)
  );

endmodule

`default_nettype wire

// ==== src/pad_pkg.sv ====
// pad side package
// pad count, routing selector and the pad configuration and
// pad output bundles

`default_nettype none

package pad_pkg;

  localparam int GPIO_W = 16;

  typedef logic [GPIO_W-1:0] gpio_t;

  // zero means not routed
  typedef logic [1:0] route_sel_t;

  typedef struct packed {
    gpio_t      gpio;
    gpio_t      oeb;
    gpio_t      pu;
    gpio_t      pd;
    route_sel_t xtal_dest;
    route_sel_t pll_dest;
    route_sel_t trap_dest;
    route_sel_t irq7_src;
    route_sel_t irq8_src;
  } pad_cfg_t;

  // all enables and pulls are active low
  typedef struct packed {
    gpio_t out;
    gpio_t outenb;
    gpio_t pullupb;
    gpio_t pulldownb;
  } pad_out_t;

endpackage

`default_nettype wire

// ==== src/sysctl_pkg.sv ====
// system control bus package
// bus widths, register page offsets, request structs and the
// register selector used between decode and register stages

`default_nettype none

package sysctl_pkg;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = DATA_W / 8;
  localparam int PAGE_BITS = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // zero wstrb marks a read
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } bus_req_t;

  typedef enum logic [3:0] {
    SEL_GPIO,
    SEL_OEB,
    SEL_PU,
    SEL_PD,
    SEL_XTAL,
    SEL_PLL,
    SEL_TRAP,
    SEL_IRQ7,
    SEL_IRQ8,
    SEL_NONE
  } reg_sel_e;

  typedef struct packed {
    reg_sel_e sel;
    data_t    wdata;
    strb_t    wstrb;
  } dec_req_t;

  // offsets inside the page
  localparam logic [PAGE_BITS-1:0] OFS_GPIO = 8'h00;
  localparam logic [PAGE_BITS-1:0] OFS_OEB  = 8'h04;
  localparam logic [PAGE_BITS-1:0] OFS_PU   = 8'h08;
  localparam logic [PAGE_BITS-1:0] OFS_PD   = 8'h0c;
  localparam logic [PAGE_BITS-1:0] OFS_XTAL = 8'h34;
  localparam logic [PAGE_BITS-1:0] OFS_PLL  = 8'h38;
  localparam logic [PAGE_BITS-1:0] OFS_TRAP = 8'h3c;
  localparam logic [PAGE_BITS-1:0] OFS_IRQ7 = 8'h40;
  localparam logic [PAGE_BITS-1:0] OFS_IRQ8 = 8'h44;

endpackage

`default_nettype wire
